// ==== project.f ====
verilog/systolic_pkg.sv
verilog/processing_element.sv
verilog/pe_array.sv
verilog/weight_load_ctrl.sv
verilog/weight_bank.sv
verilog/row_accumulator.sv
verilog/systolic_array.sv
verification/tb_systolic_array.sv

// ==== verification/tb_systolic_array.sv ====
module tb_systolic_array
    import systolic_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ARRAY_ROWS   = 4;
    localparam int ARRAY_COLS   = 4;
    localparam int NUM_SLOTS    = ARRAY_ROWS * ARRAY_COLS;
    localparam int MAX_SETS     = 8;
    localparam int PASS_CYCLES  = 12;
    localparam int IDLE_TIMEOUT = 20;

    logic                    clk_in;
    logic                    rst_in;
    logic                    load_weight_in;
    weight_t                 weight_in;
    act_t  [ARRAY_COLS-1:0]  act_col_in;
    psum_t [ARRAY_ROWS-1:0]  psum_row_in;
    psum_t [ARRAY_ROWS-1:0]  psum_row_out;
    act_t  [ARRAY_COLS-1:0]  act_col_out;

    integer seed;
    int     errors;
    int     checks;

    // mirror of the weight bank, updated by the slot counter rule
    weight_t w_model [NUM_SLOTS];
    int      slot_model;

    // activation sets and incoming sums, one row per set
    act_t  act_set  [MAX_SETS][ARRAY_COLS];
    psum_t psum_set [MAX_SETS][ARRAY_ROWS];

    systolic_array #(
        .ARRAY_ROWS (ARRAY_ROWS),
        .ARRAY_COLS (ARRAY_COLS)
    ) uut (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .load_weight_in (load_weight_in),
        .weight_in      (weight_in),
        .act_col_in     (act_col_in),
        .psum_row_in    (psum_row_in),
        .psum_row_out   (psum_row_out),
        .act_col_out    (act_col_out)
    );

    initial begin
        clk_in = 1'b0;
        forever #10 clk_in = ~clk_in;
    end

    // value in -256 .. -1
    function automatic int neg_value();
        int v;
        v = $random(seed);
        v = (v & 32'hff) + 1;
        return -v;
    endfunction

    // sum of weight x activation over the row, wrapping at 20 bits
    function automatic psum_t expected_row(input int r, input int s);
        psum_t                            acc;
        logic signed [ACT_W+WEIGHT_W-1:0] prod;
        acc = psum_set[s][r];
        for (int c = 0; c < ARRAY_COLS; c++) begin
            prod = w_model[r * ARRAY_COLS + c] * act_set[s][c];
            acc  = acc + prod;
        end
        return acc;
    endfunction

    task automatic check_row(input int r, input int s);
        psum_t exp_val;
        exp_val = expected_row(r, s);
        checks++;
        assert (psum_row_out[r] === exp_val) else begin
            errors++;
            $display("CHECK FAILED psum_row_out[%0d] set %0d: expected %h, got %h",
                     r, s, exp_val, psum_row_out[r]);
        end
    endtask

    task automatic apply_reset();
        rst_in         = 1'b0;
        load_weight_in = 1'b0;
        weight_in      = '0;
        act_col_in     = '0;
        psum_row_in    = '0;
        repeat (8) @(negedge clk_in);
        rst_in = 1'b1;
    endtask

    // polls until every output is back at zero
    task automatic wait_for_idle();
        bit idle;
        int cycles;
        idle   = 1'b0;
        cycles = 0;
        while (!idle && cycles < IDLE_TIMEOUT) begin
            @(negedge clk_in);
            act_col_in  = '0;
            psum_row_in = '0;
            idle = (psum_row_out == '0) && (act_col_out == '0);
            cycles++;
        end
        assert (idle) else begin
            errors++;
            $display("outputs did not return to zero within %0d cycles", IDLE_TIMEOUT);
        end
    endtask

    task automatic load_burst(input int count, input bit negative);
        weight_t w;
        for (int i = 0; i < count; i++) begin
            @(negedge clk_in);
            if (negative) begin
                w = weight_t'(neg_value());
            end else begin
                w = weight_t'($random(seed));
            end
            load_weight_in = 1'b1;
            weight_in      = w;
            w_model[slot_model] = w;
            slot_model = (slot_model == NUM_SLOTS - 1) ? 0 : slot_model + 1;
        end
        @(negedge clk_in);
        load_weight_in = 1'b0;
        weight_in      = '0;
        // counter restarts once load drops
        slot_model = 0;
    endtask

    task automatic fill_sets(input int nsets, input bit signed_mode);
        psum_t p;
        for (int s = 0; s < nsets; s++) begin
            for (int c = 0; c < ARRAY_COLS; c++) begin
                if (signed_mode) begin
                    act_set[s][c] = act_t'(neg_value());
                end else begin
                    act_set[s][c] = act_t'($random(seed));
                end
            end
            for (int r = 0; r < ARRAY_ROWS; r++) begin
                p = psum_t'($random(seed));
                if (p == '0) begin
                    p = 20'sd1;
                end
                psum_set[s][r] = signed_mode ? p : psum_t'(0);
            end
        end
    endtask

    // set s starts at edge s, column c at edge s + c,
    // row r result after edge s + ARRAY_COLS + r
    task automatic run_sets(input int nsets);
        int s;
        for (int n = 0; n <= nsets + ARRAY_COLS + ARRAY_ROWS; n++) begin
            @(negedge clk_in);
            for (int r = 0; r < ARRAY_ROWS; r++) begin
                s = n - 1 - ARRAY_COLS - r;
                if (s >= 0 && s < nsets) begin
                    check_row(r, s);
                end
            end
            for (int c = 0; c < ARRAY_COLS; c++) begin
                s = n - c;
                if (s >= 0 && s < nsets) begin
                    act_col_in[c] = act_set[s][c];
                end else begin
                    act_col_in[c] = '0;
                end
            end
            for (int r = 0; r < ARRAY_ROWS; r++) begin
                s = n - ARRAY_COLS - r;
                if (s >= 0 && s < nsets) begin
                    psum_row_in[r] = psum_set[s][r];
                end else begin
                    psum_row_in[r] = '0;
                end
            end
        end
    endtask

    task automatic test_reset_state();
        @(negedge clk_in);
        for (int r = 0; r < ARRAY_ROWS; r++) begin
            checks++;
            assert (psum_row_out[r] === '0) else begin
                errors++;
                $display("CHECK FAILED psum_row_out[%0d]: expected %h, got %h",
                         r, psum_t'(0), psum_row_out[r]);
            end
        end
        for (int c = 0; c < ARRAY_COLS; c++) begin
            checks++;
            assert (act_col_out[c] === '0) else begin
                errors++;
                $display("CHECK FAILED act_col_out[%0d]: expected %h, got %h",
                         c, act_t'(0), act_col_out[c]);
            end
        end
    endtask

    task automatic test_full_load();
        load_burst(NUM_SLOTS, 1'b0);
        fill_sets(1, 1'b0);
        run_sets(1);
        wait_for_idle();
    endtask

    // second burst overwrites slots 0-3 only
    task automatic test_partial_load();
        load_burst(8, 1'b0);
        load_burst(4, 1'b0);
        fill_sets(1, 1'b0);
        run_sets(1);
        wait_for_idle();
    endtask

    // weights 17-20 land in slots 0-3
    task automatic test_wraparound();
        load_burst(NUM_SLOTS + 4, 1'b0);
        fill_sets(1, 1'b0);
        run_sets(1);
        wait_for_idle();
    endtask

    task automatic test_signed_sums();
        load_burst(NUM_SLOTS, 1'b1);
        fill_sets(MAX_SETS, 1'b1);
        run_sets(MAX_SETS);
        wait_for_idle();
    endtask

    task automatic test_pass_through();
        act_t hist [PASS_CYCLES][ARRAY_COLS];
        int   k;
        for (int n = 0; n <= PASS_CYCLES + ARRAY_ROWS; n++) begin
            @(negedge clk_in);
            // driven before edge k, visible after edge k + ARRAY_ROWS
            k = n - 1 - ARRAY_ROWS;
            if (k >= 0 && k < PASS_CYCLES) begin
                for (int c = 0; c < ARRAY_COLS; c++) begin
                    checks++;
                    assert (act_col_out[c] === hist[k][c]) else begin
                        errors++;
                        $display("CHECK FAILED act_col_out[%0d] cycle %0d: expected %h, got %h",
                                 c, k, hist[k][c], act_col_out[c]);
                    end
                end
            end
            for (int c = 0; c < ARRAY_COLS; c++) begin
                if (n < PASS_CYCLES) begin
                    hist[n][c]    = act_t'($random(seed));
                    act_col_in[c] = hist[n][c];
                end else begin
                    act_col_in[c] = '0;
                end
            end
        end
        wait_for_idle();
    endtask

    initial begin
        seed       = 32'h7280;
        errors     = 0;
        checks     = 0;
        slot_model = 0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            w_model[i] = '0;
        end

        apply_reset();
        test_reset_state();
        test_full_load();
        test_partial_load();
        test_wraparound();
        test_signed_sums();
        test_pass_through();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== verilog/systolic_array.sv ====
module systolic_array
    import systolic_pkg::*;
#(
    parameter int ARRAY_ROWS = 4,
    parameter int ARRAY_COLS = 4
) (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     load_weight_in,
    input  weight_t                  weight_in,
    // activations must arrive staggered, column c one cycle after column c-1
    input  act_t  [ARRAY_COLS-1:0]   act_col_in,
    // partial sums from a previous array, row r due at k0 + ARRAY_COLS + r
    input  psum_t [ARRAY_ROWS-1:0]   psum_row_in,
    output psum_t [ARRAY_ROWS-1:0]   psum_row_out,
    // bottom row activations, passed on to a following array
    output act_t  [ARRAY_COLS-1:0]   act_col_out
);

    weight_wr_t                                  weight_wr;
    weight_t    [ARRAY_ROWS-1:0][ARRAY_COLS-1:0] weights;
    psum_t      [ARRAY_ROWS-1:0]                 row_psum;

    // serial weight loading, one slot per cycle
    weight_load_ctrl #(
        .ARRAY_ROWS (ARRAY_ROWS),
        .ARRAY_COLS (ARRAY_COLS)
    ) u_weight_load_ctrl (
        .clk_in         (clk_in),
        .rst_in         (rst_in),
        .load_weight_in (load_weight_in),
        .weight_in      (weight_in),
        .weight_wr      (weight_wr)
    );

    weight_bank #(
        .ARRAY_ROWS (ARRAY_ROWS),
        .ARRAY_COLS (ARRAY_COLS)
    ) u_weight_bank (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .weight_wr (weight_wr),
        .weights   (weights)
    );

    // the MAC grid itself
    pe_array #(
        .ARRAY_ROWS (ARRAY_ROWS),
        .ARRAY_COLS (ARRAY_COLS)
    ) u_pe_array (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .act_col_in  (act_col_in),
        .weights     (weights),
        .row_psum    (row_psum),
        .act_col_out (act_col_out)
    );

    // adds the previous array's sums at the right edge
    row_accumulator #(
        .ARRAY_ROWS (ARRAY_ROWS)
    ) u_row_accumulator (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .row_psum     (row_psum),
        .psum_row_in  (psum_row_in),
        .psum_row_out (psum_row_out)
    );

endmodule

// ==== verilog/row_accumulator.sv ====
module row_accumulator
    import systolic_pkg::*;
#(
    parameter int ARRAY_ROWS = 4
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  psum_t [ARRAY_ROWS-1:0] row_psum,
    input  psum_t [ARRAY_ROWS-1:0] psum_row_in,
    output psum_t [ARRAY_ROWS-1:0] psum_row_out
);

    psum_t [ARRAY_ROWS-1:0] psum_in_q;

    // sums from the previous array are sampled one edge before use,
    // lined up with the last element of their row
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            psum_in_q <= '0;
        end else begin
            psum_in_q <= psum_row_in;
        end
    end

    for (genvar r = 0; r < ARRAY_ROWS; r++) begin : g_row_add
        // modulo 2^PSUM_W
        assign psum_row_out[r] = row_psum[r] + psum_in_q[r];
    end

endmodule

// ==== verilog/weight_bank.sv ====
module weight_bank
    import systolic_pkg::*;
#(
    parameter int ARRAY_ROWS = 4,
    parameter int ARRAY_COLS = 4
) (
    input  logic                                    clk_in,
    input  logic                                    rst_in,
    input  weight_wr_t                              weight_wr,
    output weight_t [ARRAY_ROWS-1:0][ARRAY_COLS-1:0] weights
);

    localparam int NUM_SLOTS = ARRAY_ROWS * ARRAY_COLS;

    slot_t wr_row;
    slot_t wr_col;

    // row-major slot numbering
    assign wr_row = SLOT_W'(weight_wr.slot / ARRAY_COLS);
    assign wr_col = SLOT_W'(weight_wr.slot % ARRAY_COLS);

    // only the addressed register takes the new value, the rest hold
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            weights <= '0;
        end else if (weight_wr.en) begin
            weights[wr_row][wr_col] <= weight_wr.value;
        end
    end

    // the controller and the bank must agree on the grid size
    property p_wr_slot_valid;
        @(posedge clk_in) disable iff (!rst_in)
        weight_wr.en |-> (int'(weight_wr.slot) < NUM_SLOTS);
    endproperty

    a_wr_slot_valid: assert property (p_wr_slot_valid)
        else $error("weight write to slot %0d outside %0d slots",
                    weight_wr.slot, NUM_SLOTS);

endmodule

// ==== verilog/weight_load_ctrl.sv ====
module weight_load_ctrl
    import systolic_pkg::*;
#(
    parameter int ARRAY_ROWS = 4,
    parameter int ARRAY_COLS = 4
) (
    input  logic       clk_in,
    input  logic       rst_in,
    input  logic       load_weight_in,
    input  weight_t    weight_in,
    output weight_wr_t weight_wr
);

    localparam int LAST_SLOT = ARRAY_ROWS * ARRAY_COLS - 1;

    slot_t slot_cnt;

    // counter restarts at slot 0 whenever load drops,
    // so each burst fills the bank from the top left
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            slot_cnt <= '0;
        end else if (!load_weight_in) begin
            slot_cnt <= '0;
        end else if (slot_cnt == SLOT_W'(LAST_SLOT)) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    // write goes out in the same cycle the weight is presented
    always_comb begin
        weight_wr.en    = load_weight_in;
        weight_wr.slot  = slot_cnt;
        weight_wr.value = weight_in;
    end

    // first write of every burst lands in slot 0
    property p_burst_starts_at_zero;
        @(posedge clk_in) disable iff (!rst_in)
        $rose(load_weight_in) |-> (weight_wr.slot == '0);
    endproperty

    a_burst_starts_at_zero: assert property (p_burst_starts_at_zero)
        else $error("weight burst started at slot %0d", weight_wr.slot);

endmodule

// ==== verilog/pe_array.sv ====
module pe_array
    import systolic_pkg::*;
#(
    parameter int ARRAY_ROWS = 4,
    parameter int ARRAY_COLS = 4
) (
    input  logic                                     clk_in,
    input  logic                                     rst_in,
    input  act_t    [ARRAY_COLS-1:0]                 act_col_in,
    input  weight_t [ARRAY_ROWS-1:0][ARRAY_COLS-1:0] weights,
    output psum_t   [ARRAY_ROWS-1:0]                 row_psum,
    output act_t    [ARRAY_COLS-1:0]                 act_col_out
);

    act_t [ARRAY_COLS-1:0] act_in_q;

    // act_link[r][c] feeds element (r, c); the extra row leaves the array
    act_t  act_link  [ARRAY_ROWS+1][ARRAY_COLS];
    // psum_link[r][c] feeds element (r, c) from the left
    psum_t psum_link [ARRAY_ROWS][ARRAY_COLS+1];

    // entry register, no skew here; the source staggers the columns
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            act_in_q <= '0;
        end else begin
            act_in_q <= act_col_in;
        end
    end

    for (genvar c = 0; c < ARRAY_COLS; c++) begin : g_col_io
        assign act_link[0][c] = act_in_q[c];
        assign act_col_out[c] = act_link[ARRAY_ROWS][c];
    end

    for (genvar r = 0; r < ARRAY_ROWS; r++) begin : g_row
        // each row chain starts from zero at the left edge
        assign psum_link[r][0] = '0;
        assign row_psum[r]     = psum_link[r][ARRAY_COLS];

        for (genvar c = 0; c < ARRAY_COLS; c++) begin : g_pe
            processing_element u_pe (
                .clk_in   (clk_in),
                .rst_in   (rst_in),
                .act      (act_link[r][c]),
                .weight   (weights[r][c]),
                .psum     (psum_link[r][c]),
                .act_fwd  (act_link[r+1][c]),
                .psum_fwd (psum_link[r][c+1])
            );
        end
    end

endmodule

// ==== verilog/processing_element.sv ====
module processing_element
    import systolic_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_in,
    input  act_t    act,
    input  weight_t weight,
    input  psum_t   psum,
    output act_t    act_fwd,
    output psum_t   psum_fwd
);

    // full precision product, 18 bits for 9x9 signed
    logic signed [ACT_W+WEIGHT_W-1:0] product;

    assign product = act * weight;

    // activation moves down, partial sum moves right, both one cycle
    always_ff @(posedge clk_in or negedge rst_in) begin
        if (!rst_in) begin
            act_fwd  <= '0;
            psum_fwd <= '0;
        end else begin
            act_fwd  <= act;
            // sign extend to the chain width, overflow wraps
            psum_fwd <= psum + psum_t'(product);
        end
    end

endmodule

// ==== verilog/systolic_pkg.sv ====
package systolic_pkg;

    // element widths, shared by every block of the array
    localparam int ACT_W    = 9;
    localparam int WEIGHT_W = 9;

    // wide enough for a full row of 9x9 products plus an incoming sum;
    // anything past 2^20 simply wraps
    localparam int PSUM_W   = 20;

    // slot index into the weight bank, sized for the default 4x4 grid
    localparam int SLOT_W   = 4;

    // signed activation entering at the top of a column
    typedef logic signed [ACT_W-1:0] act_t;

    // signed weight held stationary in each processing element
    typedef logic signed [WEIGHT_W-1:0] weight_t;

    // signed partial sum, arithmetic is modulo 2^PSUM_W
    typedef logic signed [PSUM_W-1:0] psum_t;

    // slot number in row-major order, slot = row * cols + col
    typedef logic [SLOT_W-1:0] slot_t;

    // one weight write from the load controller to the weight bank
    typedef struct packed {
        logic    en;
        slot_t   slot;
        weight_t value;
    } weight_wr_t;

endpackage
